// ==== verilog/loraPkg.sv ====
`default_nettype none

package loraPkg;

    // chirp symbol value
    localparam int symbolWidth = 12;

    // spreading-factor select, codes 6 and 7 fall back to the default table
    localparam int sfSelWidth = 3;
    localparam logic [sfSelWidth-1:0] sf7 = 3'd0;
    localparam logic [sfSelWidth-1:0] sf8 = 3'd1;
    localparam logic [sfSelWidth-1:0] sf9 = 3'd2;
    localparam logic [sfSelWidth-1:0] sf10 = 3'd3;
    localparam logic [sfSelWidth-1:0] sf11 = 3'd4;
    localparam logic [sfSelWidth-1:0] sf12 = 3'd5;

    // chirp direction seen by the chirp generator
    localparam int chirpTypeWidth = 2;
    localparam logic [chirpTypeWidth-1:0] typeUp = 2'd0;
    localparam logic [chirpTypeWidth-1:0] typeDown = 2'd1;
    localparam logic [chirpTypeWidth-1:0] typeQuarterDown = 2'd2;

    // frame fields, in transmit order
    localparam int fieldWidth = 4;
    localparam logic [fieldWidth-1:0] fieldIdle = 4'd0;
    localparam logic [fieldWidth-1:0] fieldPreamble = 4'd1;
    localparam logic [fieldWidth-1:0] fieldSync0 = 4'd2;
    localparam logic [fieldWidth-1:0] fieldSync1 = 4'd3;
    localparam logic [fieldWidth-1:0] fieldDown0 = 4'd4;
    localparam logic [fieldWidth-1:0] fieldDown1 = 4'd5;
    localparam logic [fieldWidth-1:0] fieldQuarter = 4'd6;
    localparam logic [fieldWidth-1:0] fieldPayload = 4'd7;
    localparam logic [fieldWidth-1:0] fieldDone = 4'd8;

    // preamble counter, holds up to 31 upchirps
    localparam int countWidth = 5;

    // payload position and table depth
    localparam int payloadIndexWidth = 4;
    localparam int maxPayloadLen = 16;

endpackage

`default_nettype wire

// ==== verilog/frameSequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module frameSequencer #(
    parameter int preambleLen = 8,
    parameter int payloadLen = 16
) (
    input  logic                                clk,
    input  logic                                rstN,
    input  logic                                clkLock,
    input  logic                                symDone,
    output logic [loraPkg::fieldWidth-1:0]      field,
    output logic [loraPkg::payloadIndexWidth-1:0] payloadIndex
);

    import loraPkg::*;

    // last count value before leaving preamble and payload
    localparam logic [countWidth-1:0] preambleLast = countWidth'(preambleLen - 1);
    localparam logic [payloadIndexWidth-1:0] payloadLast =
        payloadIndexWidth'(payloadLen - 1);

    logic [fieldWidth-1:0] fieldNext;
    logic [countWidth-1:0] preambleCount;

    // next field, symDone only matters inside an active frame
    always_comb begin
        fieldNext = field;
        case (field)
            fieldIdle: begin
                fieldNext = fieldPreamble;
            end
            fieldPreamble: begin
                if (symDone && (preambleCount == preambleLast)) begin
                    fieldNext = fieldSync0;
                end
            end
            fieldSync0: begin
                if (symDone) begin
                    fieldNext = fieldSync1;
                end
            end
            fieldSync1: begin
                if (symDone) begin
                    fieldNext = fieldDown0;
                end
            end
            fieldDown0: begin
                if (symDone) begin
                    fieldNext = fieldDown1;
                end
            end
            fieldDown1: begin
                if (symDone) begin
                    fieldNext = fieldQuarter;
                end
            end
            fieldQuarter: begin
                if (symDone) begin
                    fieldNext = fieldPayload;
                end
            end
            fieldPayload: begin
                if (symDone && (payloadIndex == payloadLast)) begin
                    fieldNext = fieldDone;
                end
            end
            fieldDone: begin
                fieldNext = fieldDone;
            end
            default: begin
                fieldNext = fieldIdle;
            end
        endcase
        // loss of lock aborts the frame from any field
        if (!clkLock) begin
            fieldNext = fieldIdle;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            field <= fieldIdle;
        end else begin
            field <= fieldNext;
        end
    end

    // counters clear as soon as their field is left
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            preambleCount <= '0;
        end else if (fieldNext != fieldPreamble) begin
            preambleCount <= '0;
        end else if ((field == fieldPreamble) && symDone) begin
            preambleCount <= preambleCount + countWidth'(1);
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            payloadIndex <= '0;
        end else if (fieldNext != fieldPayload) begin
            payloadIndex <= '0;
        end else if ((field == fieldPayload) && symDone) begin
            payloadIndex <= payloadIndex + payloadIndexWidth'(1);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/symbolRom.sv ====
`timescale 1ns/1ns
`default_nettype none

module symbolRom (
    input  logic                                  clk,
    input  logic                                  rstN,
    input  logic [loraPkg::sfSelWidth-1:0]        sfSelect,
    input  logic [loraPkg::fieldWidth-1:0]        field,
    input  logic [loraPkg::payloadIndexWidth-1:0] payloadIndex,
    output logic [loraPkg::symbolWidth-1:0]       symVal,
    output logic [loraPkg::chirpTypeWidth-1:0]    symType,
    output logic                                  chirpRun
);

    import loraPkg::*;

    // two sync words followed by the payload entries
    localparam int tableDepth = maxPayloadLen + 2;
    localparam int tableIndexWidth = $clog2(tableDepth);

    localparam logic [symbolWidth-1:0] sf7Table [tableDepth] = '{
        12'd73, 12'd81,
        12'd70, 12'd117, 12'd13, 12'd21, 12'd5, 12'd78, 12'd94, 12'd101,
        12'd69, 12'd28, 12'd46, 12'd89, 12'd113, 12'd84, 12'd89, 12'd80
    };

    localparam logic [symbolWidth-1:0] sf8Table [tableDepth] = '{
        12'd8, 12'd16,
        12'd5, 12'd73, 12'd141, 12'd169, 12'd137, 12'd29, 12'd61, 12'd177,
        12'd2, 12'd83, 12'd106, 12'd5, 12'd49, 12'd234, 12'd22, 12'd241
    };

    localparam logic [symbolWidth-1:0] sf9Table [tableDepth] = '{
        12'd265, 12'd273,
        12'd250, 12'd330, 12'd114, 12'd106, 12'd11, 12'd306, 12'd378, 12'd411,
        12'd3, 12'd44, 12'd141, 12'd292, 12'd298, 12'd23, 12'd235, 12'd502
    };

    localparam logic [symbolWidth-1:0] sf10Table [tableDepth] = '{
        12'd521, 12'd529,
        12'd1019, 12'd951, 12'd115, 12'd234, 12'd55, 12'd622, 12'd757, 12'd819,
        12'd385, 12'd149, 12'd966, 12'd467, 12'd534, 12'd795, 12'd29, 12'd758
    };

    localparam logic [symbolWidth-1:0] sf11Table [tableDepth] = '{
        12'd1033, 12'd1041,
        12'd1530, 12'd1610, 12'd398, 12'd490, 12'd54, 12'd1262, 12'd1514, 12'd1646,
        12'd578, 12'd1207, 12'd543, 12'd153, 12'd1036, 12'd751, 12'd1552, 12'd780
    };

    // sf12 values not yet verified on air, upper half of payload is empty
    localparam logic [symbolWidth-1:0] sf12Table [tableDepth] = '{
        12'd8, 12'd16,
        12'd488, 12'd568, 12'd2427, 12'd3032, 12'd2083, 12'd476, 12'd984, 12'd1211,
        12'd0, 12'd0, 12'd0, 12'd0, 12'd0, 12'd0, 12'd0, 12'd0
    };

    // used for codes 6 and 7
    localparam logic [symbolWidth-1:0] fallbackTable [tableDepth] = '{
        12'd2057, 12'd2065,
        12'd2555, 12'd2635, 12'd399, 12'd1003, 12'd55, 12'd2543, 12'd3051, 12'd3279,
        12'd0, 12'd0, 12'd0, 12'd0, 12'd0, 12'd0, 12'd0, 12'd0
    };

    localparam logic [symbolWidth-1:0] downSf8 = 12'd254;
    localparam logic [symbolWidth-1:0] downDefault = 12'd4079;

    logic [tableIndexWidth-1:0] wordIndex;
    logic [symbolWidth-1:0] tableWord;
    logic [symbolWidth-1:0] downWord;
    logic [symbolWidth-1:0] valNext;
    logic [chirpTypeWidth-1:0] typeNext;
    logic runNext;

    // table word for the current field
    always_comb begin
        case (field)
            fieldSync0: wordIndex = tableIndexWidth'(0);
            fieldSync1: wordIndex = tableIndexWidth'(1);
            default: wordIndex = tableIndexWidth'(payloadIndex) + tableIndexWidth'(2);
        endcase
    end

    always_comb begin
        case (sfSelect)
            sf7: tableWord = sf7Table[wordIndex];
            sf8: tableWord = sf8Table[wordIndex];
            sf9: tableWord = sf9Table[wordIndex];
            sf10: tableWord = sf10Table[wordIndex];
            sf11: tableWord = sf11Table[wordIndex];
            sf12: tableWord = sf12Table[wordIndex];
            default: tableWord = fallbackTable[wordIndex];
        endcase
        downWord = (sfSelect == sf8) ? downSf8 : downDefault;
    end

    // per-field value, direction and run level
    always_comb begin
        valNext = '0;
        typeNext = typeUp;
        runNext = 1'b1;
        case (field)
            fieldPreamble: begin
                valNext = '0;
            end
            fieldSync0, fieldSync1, fieldPayload: begin
                valNext = tableWord;
            end
            fieldDown0, fieldDown1: begin
                valNext = downWord;
                typeNext = typeDown;
            end
            fieldQuarter: begin
                valNext = downWord;
                typeNext = typeQuarterDown;
            end
            default: begin
                // idle and done keep the chirp generator stopped
                runNext = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            symVal <= '0;
            symType <= typeUp;
            chirpRun <= 1'b0;
        end else begin
            symVal <= valNext;
            symType <= typeNext;
            chirpRun <= runNext;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/loraPacketGen.sv ====
`timescale 1ns/1ns
`default_nettype none

module loraPacketGen #(
    parameter int preambleLen = 8,
    parameter int payloadLen = 16
) (
    input  logic                               clk,
    input  logic                               rstN,
    input  logic                               clkLock,
    input  logic                               symDone,
    input  logic [loraPkg::sfSelWidth-1:0]     sfSelect,
    output logic [loraPkg::symbolWidth-1:0]    symVal,
    output logic [loraPkg::chirpTypeWidth-1:0] symType,
    output logic                               chirpRun
);

    import loraPkg::*;

    logic [fieldWidth-1:0] field;
    logic [payloadIndexWidth-1:0] payloadIndex;

    // frame position, one edge behind symDone
    frameSequencer #(
        .preambleLen(preambleLen),
        .payloadLen (payloadLen)
    ) i_frameSequencer (
        .clk         (clk),
        .rstN        (rstN),
        .clkLock     (clkLock),
        .symDone     (symDone),
        .field       (field),
        .payloadIndex(payloadIndex)
    );

    // registered symbol lookup, one more edge
    symbolRom i_symbolRom (
        .clk         (clk),
        .rstN        (rstN),
        .sfSelect    (sfSelect),
        .field       (field),
        .payloadIndex(payloadIndex),
        .symVal      (symVal),
        .symType     (symType),
        .chirpRun    (chirpRun)
    );

endmodule

`default_nettype wire

// ==== test/tbClock.sv ====
`timescale 1ns/1ns
`default_nettype none

module tbClock #(
    parameter int halfPeriod = 50,
    parameter int resetCycles = 16
) (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    // reset released just after an edge, like every other input
    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        #10;
        rstN = 1'b1;
    end

endmodule

`default_nettype wire

// ==== test/frameSequencer_assertions.sv ====
`timescale 1ns/1ns
`default_nettype none

module frameSequencer_assertions (
    input logic                                  clk,
    input logic                                  rstN,
    input logic                                  clkLock,
    input logic                                  symDone,
    input logic [loraPkg::fieldWidth-1:0]        field,
    input logic [loraPkg::payloadIndexWidth-1:0] payloadIndex
);

    import loraPkg::*;

    // no frame without lock
    idleWithoutLock: assert property (@(posedge clk) disable iff (!rstN)
        !clkLock |=> (field == fieldIdle))
        else $error("frame field left idle while clkLock was low");

    payloadIndexOutsidePayload: assert property (@(posedge clk) disable iff (!rstN)
        (field != fieldPayload) |-> (payloadIndex == '0))
        else $error("payload index is not zero outside the payload field");

    // a field move needs a symbol pulse or a lock edge one clock earlier
    fieldMovesOnEvent: assert property (@(posedge clk) disable iff (!rstN)
        (field != $past(field)) |->
            ($past(symDone) || ($past(clkLock) != $past(clkLock, 2))))
        else $error("frame field moved without symDone or a clkLock change");

endmodule

`default_nettype wire

// ==== test/loraPacketGenTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module loraPacketGenTb;

    import loraPkg::*;

    localparam int numRows = 7;
    localparam int preambleLen = 8;
    localparam int payloadLen = 16;
    localparam int payloadStart = preambleLen + 5;
    localparam int frameSymbols = payloadStart + payloadLen;
    // pulses sent after the frame has ended
    localparam int extraPulses = 2;
    // roughly twice seven frames at the slowest symDone spacing
    localparam int timeoutCycles = 4000;

    localparam logic [sfSelWidth-1:0] sfCodes [numRows] = '{
        3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd7
    };

    localparam logic [symbolWidth-1:0] syncTable [numRows][2] = '{
        '{12'd73, 12'd81}, '{12'd8, 12'd16}, '{12'd265, 12'd273},
        '{12'd521, 12'd529}, '{12'd1033, 12'd1041}, '{12'd8, 12'd16},
        '{12'd2057, 12'd2065}
    };

    localparam logic [symbolWidth-1:0] downTable [numRows] = '{
        12'd4079, 12'd254, 12'd4079, 12'd4079, 12'd4079, 12'd4079, 12'd4079
    };

    localparam logic [symbolWidth-1:0] payloadTable [numRows][payloadLen] = '{
        '{12'd70, 12'd117, 12'd13, 12'd21, 12'd5, 12'd78, 12'd94, 12'd101,
          12'd69, 12'd28, 12'd46, 12'd89, 12'd113, 12'd84, 12'd89, 12'd80},
        '{12'd5, 12'd73, 12'd141, 12'd169, 12'd137, 12'd29, 12'd61, 12'd177,
          12'd2, 12'd83, 12'd106, 12'd5, 12'd49, 12'd234, 12'd22, 12'd241},
        '{12'd250, 12'd330, 12'd114, 12'd106, 12'd11, 12'd306, 12'd378, 12'd411,
          12'd3, 12'd44, 12'd141, 12'd292, 12'd298, 12'd23, 12'd235, 12'd502},
        '{12'd1019, 12'd951, 12'd115, 12'd234, 12'd55, 12'd622, 12'd757, 12'd819,
          12'd385, 12'd149, 12'd966, 12'd467, 12'd534, 12'd795, 12'd29, 12'd758},
        '{12'd1530, 12'd1610, 12'd398, 12'd490, 12'd54, 12'd1262, 12'd1514, 12'd1646,
          12'd578, 12'd1207, 12'd543, 12'd153, 12'd1036, 12'd751, 12'd1552, 12'd780},
        '{12'd488, 12'd568, 12'd2427, 12'd3032, 12'd2083, 12'd476, 12'd984, 12'd1211,
          12'd0, 12'd0, 12'd0, 12'd0, 12'd0, 12'd0, 12'd0, 12'd0},
        '{12'd2555, 12'd2635, 12'd399, 12'd1003, 12'd55, 12'd2543, 12'd3051, 12'd3279,
          12'd0, 12'd0, 12'd0, 12'd0, 12'd0, 12'd0, 12'd0, 12'd0}
    };

    // lock drops after this many pulses, 0 runs the frame straight through
    localparam int abortSteps [numRows] = '{0, 0, 3, 0, 0, 0, 0};

    logic clk;
    logic rstN;
    logic clkLock;
    logic symDone;
    logic [sfSelWidth-1:0] sfSelect;
    logic [symbolWidth-1:0] symVal;
    logic [chirpTypeWidth-1:0] symType;
    logic chirpRun;

    int errorCount = 0;
    int cycleCount = 0;
    logic [31:0] lfsrState = 32'h5aa4_5497;

    tbClock #(
        .halfPeriod (50),
        .resetCycles(16)
    ) i_tbClock (
        .clk (clk),
        .rstN(rstN)
    );

    loraPacketGen i_loraPacketGen (
        .clk     (clk),
        .rstN    (rstN),
        .clkLock (clkLock),
        .symDone (symDone),
        .sfSelect(sfSelect),
        .symVal  (symVal),
        .symType (symType),
        .chirpRun(chirpRun)
    );

    bind frameSequencer frameSequencer_assertions i_frameSequencerAssertions (
        .clk         (clk),
        .rstN        (rstN),
        .clkLock     (clkLock),
        .symDone     (symDone),
        .field       (field),
        .payloadIndex(payloadIndex)
    );

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic drawBits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value = (value << 1) | int'(lfsrState[0]);
        end
    endtask

    // lands 10 ns after the n-th rising edge from now
    task automatic waitCycles(input int count);
        repeat (count) @(posedge clk);
        #10;
    endtask

    // symbol shown after step pulses since lock
    task automatic expectedSymbol(
        input int row,
        input int step,
        output logic [symbolWidth-1:0] val,
        output logic [chirpTypeWidth-1:0] kind,
        output logic run
    );
        val = '0;
        kind = typeUp;
        run = 1'b1;
        if (step < preambleLen) begin
            val = '0;
        end else if (step < preambleLen + 2) begin
            val = syncTable[row][step - preambleLen];
        end else if (step < preambleLen + 4) begin
            val = downTable[row];
            kind = typeDown;
        end else if (step == preambleLen + 4) begin
            val = downTable[row];
            kind = typeQuarterDown;
        end else if (step < frameSymbols) begin
            val = payloadTable[row][step - payloadStart];
        end else begin
            run = 1'b0;
        end
    endtask

    task automatic compareOutputs(
        input logic [symbolWidth-1:0] expVal,
        input logic [chirpTypeWidth-1:0] expType,
        input logic expRun,
        input string where
    );
        if (symVal !== expVal) begin
            $display("mismatch at %0t ns: symVal expected %0d got %0d (%s)",
                $time, expVal, symVal, where);
            errorCount++;
        end
        if (symType !== expType) begin
            $display("mismatch at %0t ns: symType expected %0d got %0d (%s)",
                $time, expType, symType, where);
            errorCount++;
        end
        if (chirpRun !== expRun) begin
            $display("mismatch at %0t ns: chirpRun expected %0b got %0b (%s)",
                $time, expRun, chirpRun, where);
            errorCount++;
        end
    endtask

    task automatic checkSymbol(input int row, input int step);
        logic [symbolWidth-1:0] expVal;
        logic [chirpTypeWidth-1:0] expType;
        logic expRun;
        expectedSymbol(row, step, expVal, expType, expRun);
        compareOutputs(expVal, expType, expRun, $sformatf("row %0d step %0d", row, step));
    endtask

    // one symDone pulse, check two cycles later, then finish the gap
    task automatic advanceSymbol(input int row, input int step);
        int gap;
        drawBits(3, gap);
        gap = gap + 3;
        symDone = 1'b1;
        waitCycles(1);
        symDone = 1'b0;
        waitCycles(1);
        checkSymbol(row, step);
        waitCycles(gap - 2);
    endtask

    task automatic runFrame(input int row);
        sfSelect = sfCodes[row];
        clkLock = 1'b0;
        waitCycles(2);
        compareOutputs('0, typeUp, 1'b0, "unlocked before frame");
        clkLock = 1'b1;
        waitCycles(2);
        checkSymbol(row, 0);
        if (abortSteps[row] != 0) begin
            for (int step = 1; step <= abortSteps[row]; step++) begin
                advanceSymbol(row, step);
            end
            clkLock = 1'b0;
            // the last preamble symbol is still in the output stage
            waitCycles(1);
            checkSymbol(row, abortSteps[row]);
            waitCycles(1);
            compareOutputs('0, typeUp, 1'b0, "after lock loss");
            waitCycles(2);
            clkLock = 1'b1;
            waitCycles(2);
            checkSymbol(row, 0);
        end
        for (int step = 1; step <= frameSymbols + extraPulses; step++) begin
            advanceSymbol(row, step);
        end
    endtask

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("timeout: frames did not complete within %0d cycles", timeoutCycles);
            $display("checks done with %0d errors", errorCount);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        clkLock = 1'b0;
        symDone = 1'b0;
        sfSelect = '0;
        @(posedge rstN);
        waitCycles(2);
        compareOutputs('0, typeUp, 1'b0, "after reset");
        for (int row = 0; row < numRows; row++) begin
            runFrame(row);
        end
        $display("checks done with %0d errors", errorCount);
        if (errorCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
verilog/loraPkg.sv
verilog/frameSequencer.sv
verilog/symbolRom.sv
verilog/loraPacketGen.sv
test/tbClock.sv
test/frameSequencer_assertions.sv
test/loraPacketGenTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator, the log decides pass or fail

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ns -Wno-fatal \
    -f sources.f --top-module loraPacketGenTb -o simv \
    && ./obj_dir/simv > sim.log 2>&1 \
    ; cat sim.log 2>/dev/null

grep -qx "Finished with no errors" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
